// ==== hdl/mem_cache_pkg.sv ====
package mem_cache_pkg;

  // widths of the memory message and cache interfaces
  localparam int addr_width_c = 32;
  localparam int data_width_c = 64;
  localparam int data_bytes_c = data_width_c / 8;

  // memory message type
  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // log2 of the number of bytes carried by a message
  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  // header of a memory command or response, echoed back unchanged
  typedef struct packed
  {
    msg_type_e               msg_type;
    msg_size_e               size;
    logic [7:0]              tag;
    logic [addr_width_c-1:0] addr;
  } mem_hdr_t;

  // single-beat command from the requester
  typedef struct packed
  {
    mem_hdr_t                hdr;
    logic [data_width_c-1:0] data;
  } mem_cmd_t;

  // single-beat response back to the requester
  typedef struct packed
  {
    mem_hdr_t                hdr;
    logic [data_width_c-1:0] data;
  } mem_resp_t;

  // opcodes understood by the blocking data cache
  typedef enum logic [3:0]
  {
    e_op_lb    = 4'h0,
    e_op_lh    = 4'h1,
    e_op_lw    = 4'h2,
    e_op_ld    = 4'h3,
    e_op_sb    = 4'h4,
    e_op_sh    = 4'h5,
    e_op_sw    = 4'h6,
    e_op_sd    = 4'h7,
    // tag store, writes an invalid tag into one block
    e_op_tagst = 4'h8
  } cache_op_e;

  // packet sent to the cache
  typedef struct packed
  {
    cache_op_e               opcode;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [data_bytes_c-1:0] mask;
  } cache_pkt_t;

endpackage

// ==== hdl/tag_clear_seq.sv ====
module tag_clear_seq
  #(
    parameter int sets_p = 16,
    parameter int ways_p = 2
  )
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    output mem_cache_pkg::cache_pkt_t clear_pkt_o,
    output logic                      clear_v_o,
    input  logic                      clear_ready_i,
    input  logic                      cache_v_i,
    output logic                      clearing_o
  );

  localparam int blocks_lp = sets_p * ways_p;
  localparam int cnt_w_lp  = $clog2(blocks_lp + 1);
  localparam int idx_w_lp  = (blocks_lp > 1) ? $clog2(blocks_lp) : 1;
  // block index sits just above the byte offset of a beat
  localparam int offset_lp = $clog2(mem_cache_pkg::data_bytes_c);
  localparam logic [cnt_w_lp-1:0] blocks_cnt_lp = cnt_w_lp'(blocks_lp);

  typedef enum logic [1:0]
  {
    st_reset,
    st_clear,
    st_ready
  } state_e;

  state_e              state_r;
  logic [cnt_w_lp-1:0] sent_r;
  logic [cnt_w_lp-1:0] recv_r;

  // commands stay blocked until the last tag store is acknowledged
  assign clearing_o = (state_r != st_ready);
  assign clear_v_o  = (state_r == st_clear) && (sent_r != blocks_cnt_lp);

  always_comb
  begin
    clear_pkt_o        = '0;
    clear_pkt_o.opcode = mem_cache_pkg::e_op_tagst;
    clear_pkt_o.addr[offset_lp +: idx_w_lp] = sent_r[idx_w_lp-1:0];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= st_reset;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      case (state_r)
        st_reset:
          state_r <= st_clear;
        st_clear:
        begin
          if (clear_v_o && clear_ready_i)
            sent_r <= sent_r + 1'b1;
          // every answer seen here is a tag store acknowledgement
          if (cache_v_i)
            recv_r <= recv_r + 1'b1;
          if ((sent_r == blocks_cnt_lp) && (recv_r == blocks_cnt_lp))
            state_r <= st_ready;
        end
        default:
          state_r <= st_ready;
      endcase
    end
  end

endmodule

// ==== hdl/cmd_translate.sv ====
module cmd_translate
  (
    input  mem_cache_pkg::mem_cmd_t   cmd_i,
    input  logic                      cmd_v_i,
    output logic                      cmd_ready_o,
    input  mem_cache_pkg::cache_pkt_t clear_pkt_i,
    input  logic                      clear_v_i,
    output logic                      clear_ready_o,
    input  logic                      clearing_i,
    input  logic                      queue_full_i,
    output logic                      hdr_push_o,
    output mem_cache_pkg::cache_pkt_t cache_pkt_o,
    output logic                      cache_pkt_v_o,
    input  logic                      cache_pkt_ready_i
  );

  mem_cache_pkg::mem_hdr_t   hdr;
  mem_cache_pkg::cache_pkt_t cmd_pkt;
  logic                      is_write;
  // byte offset inside the 64-bit word
  logic [2:0]                byte_off;

  assign hdr      = cmd_i.hdr;
  assign is_write = (hdr.msg_type == mem_cache_pkg::e_mem_wr);
  assign byte_off = hdr.addr[2:0];

  // opcode, replicated store data and byte mask
  always_comb
  begin
    cmd_pkt      = '0;
    cmd_pkt.addr = hdr.addr;
    case (hdr.size)
      mem_cache_pkg::e_size_1:
      begin
        cmd_pkt.opcode = is_write ? mem_cache_pkg::e_op_sb : mem_cache_pkg::e_op_lb;
        cmd_pkt.data   = {8{cmd_i.data[7:0]}};
        cmd_pkt.mask   = 8'b0000_0001 << byte_off;
      end
      mem_cache_pkg::e_size_2:
      begin
        cmd_pkt.opcode = is_write ? mem_cache_pkg::e_op_sh : mem_cache_pkg::e_op_lh;
        cmd_pkt.data   = {4{cmd_i.data[15:0]}};
        // offset aligned down to a halfword
        cmd_pkt.mask   = 8'b0000_0011 << {byte_off[2:1], 1'b0};
      end
      mem_cache_pkg::e_size_4:
      begin
        cmd_pkt.opcode = is_write ? mem_cache_pkg::e_op_sw : mem_cache_pkg::e_op_lw;
        cmd_pkt.data   = {2{cmd_i.data[31:0]}};
        cmd_pkt.mask   = 8'b0000_1111 << {byte_off[2], 2'b00};
      end
      default:
      begin
        cmd_pkt.opcode = is_write ? mem_cache_pkg::e_op_sd : mem_cache_pkg::e_op_ld;
        cmd_pkt.data   = cmd_i.data;
        cmd_pkt.mask   = 8'hff;
      end
    endcase
  end

  // the clear sequence owns the cache port until it finishes
  always_comb
  begin
    if (clearing_i)
    begin
      cache_pkt_o   = clear_pkt_i;
      cache_pkt_v_o = clear_v_i;
    end
    else
    begin
      cache_pkt_o   = cmd_pkt;
      // no packet without room for its header
      cache_pkt_v_o = cmd_v_i && !queue_full_i;
    end
  end

  assign clear_ready_o = clearing_i && cache_pkt_ready_i;
  assign cmd_ready_o   = !clearing_i && cache_pkt_ready_i && !queue_full_i;

  // header is queued on the same edge the cache takes the packet
  assign hdr_push_o = cmd_v_i && cmd_ready_o;

endmodule

// ==== hdl/resp_header_queue.sv ====
module resp_header_queue
  #(
    parameter int hdr_queue_els_p = 4
  )
  (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  mem_cache_pkg::mem_hdr_t hdr_i,
    input  logic                    push_i,
    output logic                    full_o,
    output mem_cache_pkg::mem_hdr_t hdr_o,
    output logic                    hdr_v_o,
    input  logic                    pop_i
  );

  localparam int ptr_w_lp = (hdr_queue_els_p > 1) ? $clog2(hdr_queue_els_p) : 1;
  localparam int cnt_w_lp = $clog2(hdr_queue_els_p + 1);
  localparam logic [ptr_w_lp-1:0] last_ptr_lp = ptr_w_lp'(hdr_queue_els_p - 1);
  localparam logic [cnt_w_lp-1:0] els_cnt_lp  = cnt_w_lp'(hdr_queue_els_p);

  mem_cache_pkg::mem_hdr_t mem_r [hdr_queue_els_p];
  logic [ptr_w_lp-1:0]     wr_ptr_r;
  logic [ptr_w_lp-1:0]     rd_ptr_r;
  logic [cnt_w_lp-1:0]     count_r;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count_r == els_cnt_lp);
  assign hdr_v_o = (count_r != '0);
  assign hdr_o   = mem_r[rd_ptr_r];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && hdr_v_o;

  // storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem_r[wr_ptr_r] <= hdr_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      if (do_pop)
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// ==== hdl/resp_assemble.sv ====
module resp_assemble
  (
    input  mem_cache_pkg::mem_hdr_t              hdr_i,
    input  logic                                 hdr_v_i,
    output logic                                 hdr_pop_o,
    input  logic                                 clearing_i,
    input  logic [mem_cache_pkg::data_width_c-1:0] cache_data_i,
    input  logic                                 cache_v_i,
    output logic                                 cache_yumi_o,
    output mem_cache_pkg::mem_resp_t             resp_o,
    output logic                                 resp_v_o,
    input  logic                                 resp_ready_i
  );

  logic [mem_cache_pkg::data_width_c-1:0] load_data;
  logic                                   resp_xfer;

  // the cache returns load bytes at the low end, keep only the requested size
  always_comb
  begin
    load_data = '0;
    case (hdr_i.size)
      mem_cache_pkg::e_size_1:
        load_data[7:0] = cache_data_i[7:0];
      mem_cache_pkg::e_size_2:
        load_data[15:0] = cache_data_i[15:0];
      mem_cache_pkg::e_size_4:
        load_data[31:0] = cache_data_i[31:0];
      default:
        load_data = cache_data_i;
    endcase
  end

  always_comb
  begin
    resp_o.hdr = hdr_i;
    if (hdr_i.msg_type == mem_cache_pkg::e_mem_rd)
      resp_o.data = load_data;
    else
      resp_o.data = '0;
  end

  // a response needs both a queued header and the cache answer
  assign resp_v_o  = hdr_v_i && cache_v_i;
  assign resp_xfer = resp_v_o && resp_ready_i;
  assign hdr_pop_o = resp_xfer;

  // tag store acknowledgements are consumed without a response
  assign cache_yumi_o = resp_xfer || (clearing_i && cache_v_i);

endmodule

// ==== hdl/mem_to_cache_top.sv ====
module mem_to_cache_top
  #(
    parameter int sets_p          = 16,
    parameter int ways_p          = 2,
    parameter int hdr_queue_els_p = 4
  )
  (
    input  logic                                   clk_i,
    input  logic                                   reset_i,

    // command channel
    input  mem_cache_pkg::mem_cmd_t                cmd_i,
    input  logic                                   cmd_v_i,
    output logic                                   cmd_ready_o,

    // response channel
    output mem_cache_pkg::mem_resp_t               resp_o,
    output logic                                   resp_v_o,
    input  logic                                   resp_ready_i,

    // cache packet channel
    output mem_cache_pkg::cache_pkt_t              cache_pkt_o,
    output logic                                   cache_pkt_v_o,
    input  logic                                   cache_pkt_ready_i,

    // cache return channel
    input  logic [mem_cache_pkg::data_width_c-1:0] cache_data_i,
    input  logic                                   cache_v_i,
    output logic                                   cache_yumi_o
  );

  mem_cache_pkg::cache_pkt_t clear_pkt;
  logic                      clear_v;
  logic                      clear_ready;
  logic                      clearing;
  logic                      queue_full;
  logic                      hdr_push;
  mem_cache_pkg::mem_hdr_t   queue_hdr;
  logic                      queue_hdr_v;
  logic                      hdr_pop;

  tag_clear_seq
    #(
      .sets_p (sets_p),
      .ways_p (ways_p)
    )
    u_tag_clear_seq
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .clear_pkt_o   (clear_pkt),
      .clear_v_o     (clear_v),
      .clear_ready_i (clear_ready),
      .cache_v_i     (cache_v_i),
      .clearing_o    (clearing)
    );

  cmd_translate u_cmd_translate
    (
      .cmd_i             (cmd_i),
      .cmd_v_i           (cmd_v_i),
      .cmd_ready_o       (cmd_ready_o),
      .clear_pkt_i       (clear_pkt),
      .clear_v_i         (clear_v),
      .clear_ready_o     (clear_ready),
      .clearing_i        (clearing),
      .queue_full_i      (queue_full),
      .hdr_push_o        (hdr_push),
      .cache_pkt_o       (cache_pkt_o),
      .cache_pkt_v_o     (cache_pkt_v_o),
      .cache_pkt_ready_i (cache_pkt_ready_i)
    );

  resp_header_queue
    #(
      .hdr_queue_els_p (hdr_queue_els_p)
    )
    u_resp_header_queue
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .hdr_i   (cmd_i.hdr),
      .push_i  (hdr_push),
      .full_o  (queue_full),
      .hdr_o   (queue_hdr),
      .hdr_v_o (queue_hdr_v),
      .pop_i   (hdr_pop)
    );

  resp_assemble u_resp_assemble
    (
      .hdr_i        (queue_hdr),
      .hdr_v_i      (queue_hdr_v),
      .hdr_pop_o    (hdr_pop),
      .clearing_i   (clearing),
      .cache_data_i (cache_data_i),
      .cache_v_i    (cache_v_i),
      .cache_yumi_o (cache_yumi_o),
      .resp_o       (resp_o),
      .resp_v_o     (resp_v_o),
      .resp_ready_i (resp_ready_i)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen
  #(
    parameter int period_p = 100
  )
  (
    output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
  end

  // free-running clock, half a period per phase
  always #(period_p / 2) clk_o = ~clk_o;

endmodule

// ==== test/cache_model.sv ====
module cache_model
  #(
    parameter int sets_p = 16,
    parameter int ways_p = 2
  )
  (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  mem_cache_pkg::cache_pkt_t              pkt_i,
    input  logic                                   pkt_v_i,
    output logic                                   pkt_ready_o,
    output logic [mem_cache_pkg::data_width_c-1:0] data_o,
    output logic                                   v_o,
    input  logic                                   yumi_i,
    output int                                     tagst_cnt_o,
    output int                                     tagst_distinct_o,
    output int                                     pending_o
  );

  localparam int blocks_lp = sets_p * ways_p;
  localparam int idx_w_lp  = (blocks_lp > 1) ? $clog2(blocks_lp) : 1;
  localparam int offset_lp = $clog2(mem_cache_pkg::data_bytes_c);

  logic [7:0]  mem [1024];
  logic [63:0] answers [$];
  bit          seen [blocks_lp];
  int          tagst_cnt;
  int          tagst_distinct;
  int          pending;

  assign tagst_cnt_o      = tagst_cnt;
  assign tagst_distinct_o = tagst_distinct;
  assign pending_o        = pending;

  initial
  begin
    // fill pattern covers every address bit of the 1 KB array
    for (int i = 0; i < 1024; i++)
      mem[i] = 8'((i * 7) ^ (i >> 5));
    pkt_ready_o = 1'b0;
    v_o         = 1'b0;
    data_o      = '0;
  end

  // executes one packet and returns the answer data
  function automatic logic [63:0] apply_pkt(mem_cache_pkg::cache_pkt_t p);
    logic [63:0] d;
    logic [9:0]  base;
    int          idx;
    int          n;
    d    = '0;
    base = p.addr[9:0];
    case (p.opcode)
      mem_cache_pkg::e_op_tagst:
      begin
        tagst_cnt++;
        idx = int'(p.addr[offset_lp +: idx_w_lp]);
        if ((idx < blocks_lp) && !seen[idx])
        begin
          seen[idx] = 1'b1;
          tagst_distinct++;
        end
      end
      mem_cache_pkg::e_op_sb, mem_cache_pkg::e_op_sh,
      mem_cache_pkg::e_op_sw, mem_cache_pkg::e_op_sd:
      begin
        for (int i = 0; i < 8; i++)
          if (p.mask[i])
            mem[{base[9:3], 3'(i)}] = p.data[8*i +: 8];
      end
      default:
      begin
        // load opcodes carry log2 of the byte count in the low bits
        n = 1 << p.opcode[1:0];
        for (int i = 0; i < n; i++)
          d[8*i +: 8] = mem[base + 10'(i)];
      end
    endcase
    return d;
  endfunction

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      answers.delete();
      foreach (seen[i])
        seen[i] = 1'b0;
      tagst_cnt      = 0;
      tagst_distinct = 0;
      pending        = 0;
      pkt_ready_o <= 1'b0;
      v_o         <= 1'b0;
      data_o      <= '0;
    end
    else
    begin
      if (v_o && yumi_i)
        void'(answers.pop_front());
      if (pkt_v_i && pkt_ready_o)
        answers.push_back(apply_pkt(pkt_i));
      pending = answers.size();
      // random stalls on both channels
      pkt_ready_o <= ($urandom % 4) != 0;
      v_o         <= (answers.size() != 0) && (($urandom % 4) != 0);
      data_o      <= (answers.size() != 0) ? answers[0] : '0;
    end
  end

endmodule

// ==== test/mem_to_cache_tb.sv ====
module mem_to_cache_tb;

  localparam int sets_p          = 16;
  localparam int ways_p          = 2;
  localparam int hdr_queue_els_p = 4;
  localparam int blocks_lp       = sets_p * ways_p;
  localparam int timeout_lp      = 2000;

  logic                      clk;
  logic                      reset;
  mem_cache_pkg::mem_cmd_t   cmd;
  logic                      cmd_v;
  logic                      cmd_ready;
  mem_cache_pkg::mem_resp_t  resp;
  logic                      resp_v;
  logic                      resp_ready;
  mem_cache_pkg::cache_pkt_t cache_pkt;
  logic                      cache_pkt_v;
  logic                      cache_pkt_ready;
  logic [63:0]               cache_data;
  logic                      cache_v;
  logic                      cache_yumi;
  int                        tagst_cnt;
  int                        tagst_distinct;
  int                        pending;

  logic [7:0]                shadow [1024];
  mem_cache_pkg::mem_resp_t  expected [$];
  mem_cache_pkg::mem_resp_t  exp_resp;
  int                        accepted;
  int                        received;
  int                        checks;
  int                        errors;
  int                        tests_passed;
  int                        tests_failed;
  bit                        backpressure;

  tb_clock_gen #(.period_p(100)) u_clock (.clk_o(clk));

  mem_to_cache_top
    #(
      .sets_p          (sets_p),
      .ways_p          (ways_p),
      .hdr_queue_els_p (hdr_queue_els_p)
    )
    u_mem_to_cache_top
    (
      .clk_i             (clk),
      .reset_i           (reset),
      .cmd_i             (cmd),
      .cmd_v_i           (cmd_v),
      .cmd_ready_o       (cmd_ready),
      .resp_o            (resp),
      .resp_v_o          (resp_v),
      .resp_ready_i      (resp_ready),
      .cache_pkt_o       (cache_pkt),
      .cache_pkt_v_o     (cache_pkt_v),
      .cache_pkt_ready_i (cache_pkt_ready),
      .cache_data_i      (cache_data),
      .cache_v_i         (cache_v),
      .cache_yumi_o      (cache_yumi)
    );

  cache_model #(.sets_p(sets_p), .ways_p(ways_p)) u_cache_model
    (
      .clk_i            (clk),
      .reset_i          (reset),
      .pkt_i            (cache_pkt),
      .pkt_v_i          (cache_pkt_v),
      .pkt_ready_o      (cache_pkt_ready),
      .data_o           (cache_data),
      .v_o              (cache_v),
      .yumi_i           (cache_yumi),
      .tagst_cnt_o      (tagst_cnt),
      .tagst_distinct_o (tagst_distinct),
      .pending_o        (pending)
    );

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // expected response from the shadow memory, which follows every write
  function automatic mem_cache_pkg::mem_resp_t ref_resp(mem_cache_pkg::mem_cmd_t c);
    mem_cache_pkg::mem_resp_t r;
    int                       n;
    r.hdr  = c.hdr;
    r.data = '0;
    n      = 1 << int'(c.hdr.size);
    for (int i = 0; i < n; i++)
      if (c.hdr.msg_type == mem_cache_pkg::e_mem_wr)
        shadow[c.hdr.addr[9:0] + 10'(i)] = c.data[8*i +: 8];
      else
        r.data[8*i +: 8] = shadow[c.hdr.addr[9:0] + 10'(i)];
    return r;
  endfunction

  task automatic send_cmd(mem_cache_pkg::msg_type_e t, mem_cache_pkg::msg_size_e s,
                          logic [7:0] tag, logic [9:0] addr, logic [63:0] data);
    mem_cache_pkg::mem_cmd_t c;
    int                      waited;
    c.hdr.msg_type = t;
    c.hdr.size     = s;
    c.hdr.tag      = tag;
    c.hdr.addr     = 32'(addr);
    c.data         = data;
    waited         = 0;
    cmd   <= c;
    cmd_v <= 1'b1;
    do
    begin
      @(posedge clk);
      waited++;
      if (waited > timeout_lp)
        abort_run("command was never accepted by the bridge");
    end
    while (!cmd_ready);
    expected.push_back(ref_resp(c));
    accepted++;
  endtask

  task automatic send_random(logic [7:0] tag);
    mem_cache_pkg::msg_size_e s;
    logic [9:0]               a;
    s = mem_cache_pkg::msg_size_e'($urandom % 4);
    // address aligned down to the access size
    a = 10'($urandom) & ~10'((1 << int'(s)) - 1);
    send_cmd(mem_cache_pkg::msg_type_e'($urandom % 2), s, tag, a, {$urandom, $urandom});
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    cmd_v <= 1'b0;
    while (received != accepted)
    begin
      @(posedge clk);
      waited++;
      if (waited > timeout_lp)
        abort_run("outstanding responses never arrived");
    end
  endtask

  task automatic report_test(string name, int err_before);
    if (errors == err_before)
    begin
      tests_passed++;
      $display("PASS: %s", name);
    end
    else
    begin
      tests_failed++;
      $display("FAIL: %s", name);
    end
  endtask

  always @(posedge clk)
  begin
    if (backpressure)
      resp_ready <= ($urandom % 3) != 0;
    else
      resp_ready <= 1'b1;
  end

  // compares every response transfer against the oldest expected one
  always @(posedge clk)
  begin
    if (!reset && resp_v && resp_ready)
    begin
      if (expected.size() == 0)
      begin
        errors++;
        $display("ERROR at %0t: response arrived with no command outstanding", $time);
      end
      else
      begin
        exp_resp = expected.pop_front();
        check_value("resp_o.hdr", resp.hdr, exp_resp.hdr);
        check_value("resp_o.data", resp.data, exp_resp.data);
      end
      received++;
    end
    if (accepted - received > hdr_queue_els_p)
    begin
      errors++;
      $display("ERROR at %0t: more commands in flight than the header queue holds", $time);
    end
  end

  initial
  begin
    int err_before;
    int waited;
    void'($urandom(32'h7e80));
    reset        = 1'b1;
    cmd          = '0;
    cmd_v        = 1'b0;
    resp_ready   = 1'b0;
    backpressure = 1'b0;
    accepted     = 0;
    received     = 0;
    checks       = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < 1024; i++)
      shadow[i] = 8'((i * 7) ^ (i >> 5));
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // the bridge must finish the tag clear before it takes a command
    err_before = errors;
    waited     = 0;
    while (!cmd_ready)
    begin
      @(posedge clk);
      waited++;
      if (waited > timeout_lp)
        abort_run("command ready never rose after the tag clear");
    end
    check_value("tagst_count", tagst_cnt, blocks_lp);
    check_value("tagst_distinct", tagst_distinct, blocks_lp);
    check_value("tagst_pending", pending, 0);
    report_test("reset clear", err_before);

    err_before = errors;
    for (int s = 0; s < 4; s++)
      send_cmd(mem_cache_pkg::e_mem_wr, mem_cache_pkg::msg_size_e'(s), 8'(s),
               10'h100 + 10'(s * 8), {$urandom, $urandom});
    for (int s = 0; s < 4; s++)
      for (int r = 0; r < 4; r++)
        send_cmd(mem_cache_pkg::e_mem_rd, mem_cache_pkg::msg_size_e'(r), 8'(16 + s * 4 + r),
                 10'h100 + 10'(s * 8), 64'h0);
    wait_drain();
    report_test("aligned reads and writes", err_before);

    err_before = errors;
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(mem_cache_pkg::e_mem_wr, mem_cache_pkg::e_size_1, 8'(i), 10'h210 + 10'(i),
               {$urandom, $urandom});
      send_cmd(mem_cache_pkg::e_mem_rd, mem_cache_pkg::e_size_8, 8'(i), 10'h210, 64'h0);
    end
    for (int i = 0; i < 4; i++)
    begin
      send_cmd(mem_cache_pkg::e_mem_wr, mem_cache_pkg::e_size_2, 8'(i), 10'h218 + 10'(2 * i),
               {$urandom, $urandom});
      send_cmd(mem_cache_pkg::e_mem_rd, mem_cache_pkg::e_size_8, 8'(i), 10'h218, 64'h0);
    end
    wait_drain();
    report_test("sub-word placement", err_before);

    err_before = errors;
    for (int i = 0; i < 16; i++)
      send_random(8'h80 + 8'(i));
    wait_drain();
    report_test("header echo and ordering", err_before);

    err_before   = errors;
    backpressure = 1'b1;
    for (int i = 0; i < 64; i++)
      send_random(8'(i));
    wait_drain();
    backpressure = 1'b0;
    report_test("back-pressure", err_before);

    $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
hdl/mem_cache_pkg.sv
hdl/tag_clear_seq.sv
hdl/cmd_translate.sv
hdl/resp_header_queue.sv
hdl/resp_assemble.sv
hdl/mem_to_cache_top.sv
test/tb_clock_gen.sv
test/cache_model.sv
test/mem_to_cache_tb.sv

// ==== Bender.yml ====
package:
  name: mem_to_cache

sources:
  - files:
      - hdl/mem_cache_pkg.sv
      - hdl/tag_clear_seq.sv
      - hdl/cmd_translate.sv
      - hdl/resp_header_queue.sv
      - hdl/resp_assemble.sv
      - hdl/mem_to_cache_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/cache_model.sv
      - test/mem_to_cache_tb.sv
